/* verilog.f */
src/ft_ex_pkg.sv
src/alu_lane.sv
src/lane_voter.sv
src/fault_counter.sv
src/spare_fsm.sv
src/ft_ex_stage.sv
tests/tb_clock.sv
tests/tb_ft_ex_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ft_ex_stage \
  -f verilog.f \
  -o sim_ft_ex_stage

./obj_dir/sim_ft_ex_stage

/* tests/tb_ft_ex_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for ft_ex_stage, FAULT_THRESH 4, one request every 4 cycles
// Expected values come from a model of voting, counters and lane spares
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ft_ex_stage import ft_ex_pkg::*; ();

  localparam int          CLK_PERIOD_NS   = 100;
  localparam int          RESET_CYCLES    = 10;
  localparam fault_cnt_t  FAULT_THRESH    = 9'd4;
  localparam int          REQ_SPACING     = 4;
  localparam int          MAX_REQUESTS    = 64;
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + MAX_REQUESTS * REQ_SPACING + 100;
  localparam logic [31:0] SEED            = 32'h23554f82;

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  alu_req_t                   req;
  lane_mask_t                 fault_inject;
  logic                       result_valid;
  word_t                      result;
  logic                       cmp;
  vote_status_t               status;
  fault_cnt_t [NUM_LANES-1:0] fault_count;
  lane_mask_t                 fault_perf;
  logic                       degraded;

  // Model state, lined up cycle by cycle with the DUT outputs
  string                      test_name  = "reset";
  logic                       exp_valid  = 1'b0;
  word_t                      exp_result = '0;
  logic                       exp_cmp    = 1'b0;
  vote_status_t               exp_status = '0;
  fault_cnt_t [NUM_LANES-1:0] exp_count  = '0;
  lane_mask_t                 exp_perf   = '0;
  lane_mask_t                 mdl_perm   = '0;
  lane_sel_t                  mdl_sel    = '{first: 2'd0, second: 2'd1, third: 2'd2};
  fault_mode_e                mdl_mode   = MODE_FULL;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_tb_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ft_ex_stage #(
    .FAULT_THRESH (FAULT_THRESH)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .fault_inject_i (fault_inject),
    .result_valid_o (result_valid),
    .result_o       (result),
    .cmp_o          (cmp),
    .status_o       (status),
    .fault_count_o  (fault_count),
    .fault_perf_o   (fault_perf),
    .degraded_o     (degraded)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped");
  endtask

  // Fault-free lane output
  function automatic lane_res_t golden_alu(input alu_req_t r);
    lane_res_t res;
    res = '0;
    case (r.op)
      ALU_ADD:  res.result = r.a + r.b;
      ALU_SUB:  res.result = r.a - r.b;
      ALU_AND:  res.result = r.a & r.b;
      ALU_OR:   res.result = r.a | r.b;
      ALU_XOR:  res.result = r.a ^ r.b;
      ALU_SLT:  res.cmp = ($signed(r.a) < $signed(r.b));
      ALU_SLTU: res.cmp = (r.a < r.b);
      default:  res.cmp = (r.a == r.b);
    endcase
    // Branch decision also shows up zero-extended in the word
    if (r.op inside {ALU_SLT, ALU_SLTU, ALU_EQ}) begin
      res.result = {31'b0, res.cmp};
    end
    return res;
  endfunction

  // An upset on lane k flips result bit k
  function automatic lane_res_t upset_lane(input lane_res_t good, input int lane,
                                           input logic hit);
    lane_res_t res;
    res = good;
    if (hit) begin
      res.result[lane] = ~res.result[lane];
    end
    return res;
  endfunction

  // Two out of three wins, a three-way split keeps the first lane uncorrected
  function automatic void majority_vote(input lane_res_t r1, input lane_res_t r2,
                                        input lane_res_t r3, output lane_res_t voted,
                                        output vote_status_t st);
    voted        = r1;
    st.detected  = 1'b1;
    st.corrected = 1'b1;
    if ((r1 == r2) && (r2 == r3)) begin
      st = '0;
    end else if ((r1 != r2) && (r1 != r3)) begin
      if (r2 == r3) begin
        voted = r2;
      end else begin
        st.corrected = 1'b0;
      end
    end
  endfunction

  function automatic alu_req_t random_request(input alu_op_e op);
    alu_req_t r;
    r.op = op;
    r.a  = $urandom();
    r.b  = $urandom();
    return r;
  endfunction

  function automatic alu_op_e random_op();
    logic [31:0] rnd;
    rnd = $urandom();
    return alu_op_e'(rnd[2:0]);
  endfunction

  // One strobe, then the output cycle, the count update and the perf pulse
  task automatic run_request(input alu_req_t r, input lane_mask_t inj);
    lane_res_t                  good;
    lane_res_t                  lane_out [NUM_LANES];
    lane_res_t                  voted;
    vote_status_t               st;
    lane_mask_t                 lost;
    lane_mask_t                 perm;
    fault_cnt_t [NUM_LANES-1:0] cnt;
    @(posedge clk);
    req_valid    <= 1'b1;
    req          <= r;
    fault_inject <= inj;
    // Voter samples here with the selection it holds now
    @(posedge clk);
    req_valid    <= 1'b0;
    fault_inject <= '0;
    good = golden_alu(r);
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_out[k] = upset_lane(good, k, inj[k]);
    end
    majority_vote(lane_out[mdl_sel.first], lane_out[mdl_sel.second],
                  lane_out[mdl_sel.third], voted, st);
    lost                 = '0;
    lost[mdl_sel.first]  = (lane_out[mdl_sel.first] != voted);
    lost[mdl_sel.second] = (lane_out[mdl_sel.second] != voted);
    lost[mdl_sel.third]  = (lane_out[mdl_sel.third] != voted);
    exp_valid  <= 1'b1;
    exp_result <= voted.result;
    exp_cmp    <= voted.cmp;
    exp_status <= st;
    // Result drops, losers get counted
    @(posedge clk);
    exp_valid  <= 1'b0;
    exp_result <= '0;
    exp_cmp    <= 1'b0;
    exp_status <= '0;
    cnt  = exp_count;
    perm = mdl_perm;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (lost[k] && (cnt[k] != '1)) begin
        cnt[k] = cnt[k] + 9'd1;
      end
      if (cnt[k] >= FAULT_THRESH) begin
        perm[k] = 1'b1;
      end
    end
    exp_count <= cnt;
    exp_perf  <= perm & ~mdl_perm;
    mdl_perm  <= perm;
    @(posedge clk);
    exp_perf  <= '0;
  endtask

  // Spare handling, one step per clock like the stage itself
  always @(posedge clk) begin : spare_model
    lane_mask_t voting;
    voting                 = '0;
    voting[mdl_sel.first]  = 1'b1;
    voting[mdl_sel.second] = 1'b1;
    voting[mdl_sel.third]  = 1'b1;
    if (rst_n && ((voting & mdl_perm) != '0)) begin
      if (mdl_mode == MODE_FULL) begin
        mdl_mode <= MODE_SPARED;
        if (mdl_perm[mdl_sel.first]) begin
          mdl_sel.first <= 2'd3;
        end else if (mdl_perm[mdl_sel.second]) begin
          mdl_sel.second <= 2'd3;
        end else begin
          mdl_sel.third <= 2'd3;
        end
      end else begin
        mdl_mode <= MODE_DEGRADED;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  chk_valid: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid == exp_valid)
    else stop_with_failure($sformatf("Fail %s: result_valid_o expected %0b actual %0b",
                                     test_name, exp_valid, result_valid));

  chk_result: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> (result == exp_result))
    else stop_with_failure($sformatf("Fail %s: result_o expected %h actual %h",
                                     test_name, exp_result, result));

  chk_cmp: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> (cmp == exp_cmp))
    else stop_with_failure($sformatf("Fail %s: cmp_o expected %0b actual %0b",
                                     test_name, exp_cmp, cmp));

  chk_status: assert property (@(posedge clk) disable iff (!rst_n)
    status == exp_status)
    else stop_with_failure($sformatf("Fail %s: status_o expected %b actual %b",
                                     test_name, exp_status, status));

  chk_count: assert property (@(posedge clk) disable iff (!rst_n)
    fault_count == exp_count)
    else stop_with_failure($sformatf("Fail %s: fault_count_o expected %h actual %h",
                                     test_name, exp_count, fault_count));

  chk_perf: assert property (@(posedge clk) disable iff (!rst_n)
    fault_perf == exp_perf)
    else stop_with_failure($sformatf("Fail %s: fault_perf_o expected %b actual %b",
                                     test_name, exp_perf, fault_perf));

  chk_degraded: assert property (@(posedge clk) disable iff (!rst_n)
    degraded == (mdl_mode == MODE_DEGRADED))
    else stop_with_failure($sformatf("Fail %s: degraded_o expected %0b actual %0b",
                                     test_name, (mdl_mode == MODE_DEGRADED), degraded));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    alu_req_t r;
    void'($urandom(SEED));
    req_valid    = 1'b0;
    req          = '0;
    fault_inject = '0;
    wait (rst_n === 1'b1);

    test_name = "idle_after_reset";
    repeat (8) @(posedge clk);

    // Four of each op, half of the EQ requests with equal operands
    test_name = "clean_ops";
    for (int op_i = 0; op_i < 8; op_i++) begin
      for (int n = 0; n < 4; n++) begin
        r = random_request(alu_op_e'(op_i[2:0]));
        if ((r.op == ALU_EQ) && n[0]) begin
          r.b = r.a;
        end
        run_request(r, 4'b0000);
      end
    end

    test_name = "single_upset";
    for (int lane = 0; lane < 3; lane++) begin
      run_request(random_request(random_op()), 4'b0001 << lane);
    end
    test_name = "spare_only_upset";
    run_request(random_request(random_op()), 4'b1000);

    // First lane's flipped word wins, the other two are blamed
    test_name = "double_upset";
    run_request(random_request(random_op()), 4'b0011);

    test_name = "lane1_permanent";
    while (!mdl_perm[1]) begin
      run_request(random_request(random_op()), 4'b0010);
    end
    test_name = "lane1_replaced";
    run_request(random_request(random_op()), 4'b0010);
    run_request(random_request(random_op()), 4'b1000);

    test_name = "lane0_permanent";
    while (!mdl_perm[0]) begin
      run_request(random_request(random_op()), 4'b0001);
    end
    test_name = "degraded_hold";
    run_request(random_request(random_op()), 4'b0000);
    run_request(random_request(random_op()), 4'b0100);
    run_request(random_request(random_op()), 4'b0000);

    repeat (4) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

  // Whole sequence bounded by the request budget
  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    stop_with_failure("Timeout: the test sequence did not finish in time");
  end

endmodule

/* tests/tb_clock.sv */
////////////////////////////////////////////////////////////////////////////
// Free-running testbench clock, reset low for RESET_CYCLES rising edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a rising edge, like any other driven input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* src/ft_ex_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Voted ALU result one cycle after the strobe, no back-pressure
// Lane selection follows permanent faults, three cycles after the vote
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ft_ex_stage import ft_ex_pkg::*; #(
  parameter fault_cnt_t FAULT_THRESH = 9'd4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid_i,
  input  alu_req_t                   req_i,
  input  lane_mask_t                 fault_inject_i,
  output logic                       result_valid_o,
  output word_t                      result_o,
  output logic                       cmp_o,
  output vote_status_t               status_o,
  output fault_cnt_t [NUM_LANES-1:0] fault_count_o,
  output lane_mask_t                 fault_perf_o,
  output logic                       degraded_o
);

  lane_res_t [NUM_LANES-1:0] lane_res;
  lane_res_t                 voted_res;
  lane_sel_t                 lane_sel;
  lane_mask_t                mismatch;
  lane_mask_t                permanent;

  ////////////////////////////////////////////////////////////////////////////
  // Redundant lanes, all fed the same request
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    alu_lane #(
      .LANE_ID (lane_idx_t'(k))
    ) i_alu_lane (
      .req_i    (req_i),
      .inject_i (fault_inject_i[k]),
      .res_o    (lane_res[k])
    );
  end

  lane_voter i_lane_voter (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .lanes_i     (lane_res),
    .sel_i       (lane_sel),
    .valid_o     (result_valid_o),
    .res_o       (voted_res),
    .status_o    (status_o),
    .mismatch_o  (mismatch)
  );

  // Branch decision travels as the compare bit
  assign result_o = voted_res.result;
  assign cmp_o    = voted_res.cmp;

  ////////////////////////////////////////////////////////////////////////////
  // Fault tracking and lane replacement
  ////////////////////////////////////////////////////////////////////////////

  fault_counter #(
    .FAULT_THRESH (FAULT_THRESH)
  ) i_fault_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .mismatch_i  (mismatch),
    .count_o     (fault_count_o),
    .permanent_o (permanent),
    .perf_o      (fault_perf_o)
  );

  spare_fsm i_spare_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .permanent_i (permanent),
    .sel_o       (lane_sel),
    .degraded_o  (degraded_o)
  );

endmodule

/* src/spare_fsm.sv */
////////////////////////////////////////////////////////////////////////////
// Lane 3 is the only spare, a second loss leaves the stage degraded
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spare_fsm import ft_ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  lane_mask_t permanent_i,
  output lane_sel_t  sel_o,
  output logic       degraded_o
);

  localparam lane_sel_t SEL_FULL  = '{first: 2'd0, second: 2'd1, third: 2'd2};
  localparam lane_idx_t SPARE_IDX = 2'd3;

  fault_mode_e state_q;
  fault_mode_e state_d;
  lane_sel_t   sel_d;
  lane_mask_t  hit;

  // Permanent flags that hit a lane still in the vote
  always_comb begin
    hit = '0;
    hit[sel_o.first]  = permanent_i[sel_o.first];
    hit[sel_o.second] = permanent_i[sel_o.second];
    hit[sel_o.third]  = permanent_i[sel_o.third];
  end

  always_comb begin
    state_d = state_q;
    sel_d   = sel_o;
    case (state_q)
      MODE_FULL: begin
        if (hit != '0) begin
          state_d = MODE_SPARED;
          // One slot per edge, a second hit is seen next cycle
          if (hit[sel_o.first]) begin
            sel_d.first = SPARE_IDX;
          end else if (hit[sel_o.second]) begin
            sel_d.second = SPARE_IDX;
          end else begin
            sel_d.third = SPARE_IDX;
          end
        end
      end
      MODE_SPARED: begin
        // No spare left, keep voting as is
        if (hit != '0) begin
          state_d = MODE_DEGRADED;
        end
      end
      default: state_d = MODE_DEGRADED;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MODE_FULL;
      sel_o   <= SEL_FULL;
    end else begin
      state_q <= state_d;
      sel_o   <= sel_d;
    end
  end

  assign degraded_o = (state_q == MODE_DEGRADED);

  // Voter relies on three different lanes
  a_sel_distinct: assert property (@(posedge clk) disable iff (!rst_n)
    (sel_o.first != sel_o.second) && (sel_o.first != sel_o.third) &&
    (sel_o.second != sel_o.third));

endmodule

/* src/fault_counter.sv */
////////////////////////////////////////////////////////////////////////////
// A lane whose lost-vote count reaches FAULT_THRESH stays faulty until reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fault_counter import ft_ex_pkg::*; #(
  parameter fault_cnt_t FAULT_THRESH = 9'd4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  lane_mask_t                   mismatch_i,
  output fault_cnt_t [NUM_LANES-1:0]   count_o,
  output lane_mask_t                   permanent_o,
  output lane_mask_t                   perf_o
);

  fault_cnt_t [NUM_LANES-1:0] count_d;
  lane_mask_t                 permanent_d;

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      count_d[k] = count_o[k];
      // Saturate instead of wrapping
      if (mismatch_i[k] && (count_o[k] != '1)) begin
        count_d[k] = count_o[k] + 9'd1;
      end
      // Flag on the same edge the count reaches the threshold
      permanent_d[k] = permanent_o[k] || (count_d[k] >= FAULT_THRESH);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_o     <= '0;
      permanent_o <= '0;
      perf_o      <= '0;
    end else begin
      count_o     <= count_d;
      permanent_o <= permanent_d;
      // One pulse per lane on the rising flag
      perf_o      <= permanent_d & ~permanent_o;
    end
  end

  // Sticky flags
  a_perm_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(permanent_o) & ~permanent_o) == '0);

endmodule

/* src/lane_voter.sv */
////////////////////////////////////////////////////////////////////////////
// Majority vote over the three selected lanes, outputs one cycle later
// sel_i must hold three distinct lanes, the fourth lane is ignored
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_voter import ft_ex_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid_i,
  input  lane_res_t [NUM_LANES-1:0]   lanes_i,
  input  lane_sel_t                   sel_i,
  output logic                        valid_o,
  output lane_res_t                   res_o,
  output vote_status_t                status_o,
  output lane_mask_t                  mismatch_o
);

  lane_res_t    v_first;
  lane_res_t    v_second;
  lane_res_t    v_third;
  logic         eq_fs;
  logic         eq_ft;
  logic         eq_st;
  lane_res_t    voted;
  vote_status_t status_d;
  lane_mask_t   mismatch_d;
  lane_mask_t   sel_mask;

  // Pick the voting lanes
  assign v_first  = lanes_i[sel_i.first];
  assign v_second = lanes_i[sel_i.second];
  assign v_third  = lanes_i[sel_i.third];

  assign eq_fs = (v_first == v_second);
  assign eq_ft = (v_first == v_third);
  assign eq_st = (v_second == v_third);

  ////////////////////////////////////////////////////////////////////////////
  // Majority logic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // First lane wins when it agrees with anyone, or when nobody agrees
    if (eq_fs || eq_ft) begin
      voted = v_first;
    end else if (eq_st) begin
      voted = v_second;
    end else begin
      voted = v_first;
    end
    status_d.detected  = !(eq_fs && eq_ft);
    status_d.corrected = status_d.detected && (eq_fs || eq_ft || eq_st);
    // Blame every selected lane that disagrees with the output
    mismatch_d                = '0;
    mismatch_d[sel_i.first]   = (v_first != voted);
    mismatch_d[sel_i.second]  = (v_second != voted);
    mismatch_d[sel_i.third]   = (v_third != voted);
  end

  // Selected lanes as a mask
  always_comb begin
    sel_mask               = '0;
    sel_mask[sel_i.first]  = 1'b1;
    sel_mask[sel_i.second] = 1'b1;
    sel_mask[sel_i.third]  = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o    <= 1'b0;
      res_o      <= '0;
      status_o   <= '0;
      mismatch_o <= '0;
    end else if (req_valid_i) begin
      valid_o    <= 1'b1;
      res_o      <= voted;
      status_o   <= status_d;
      mismatch_o <= mismatch_d;
    end else begin
      // Single-cycle strobe, nothing held
      valid_o    <= 1'b0;
      res_o      <= '0;
      status_o   <= '0;
      mismatch_o <= '0;
    end
  end

  // A correction always comes with a detection
  a_corr_needs_det: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(status_o.corrected) |-> status_o.detected);

  // Blame lands only on lanes that voted on that request
  a_mismatch_selected: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> ((mismatch_o & ~$past(sel_mask)) == '0));

endmodule

/* src/alu_lane.sv */
////////////////////////////////////////////////////////////////////////////
// Purely combinational lane, inject_i flips result bit LANE_ID only
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_lane import ft_ex_pkg::*; #(
  parameter lane_idx_t LANE_ID = 2'd0
) (
  input  alu_req_t  req_i,
  input  logic      inject_i,
  output lane_res_t res_o
);

  word_t result;
  logic  cmp;
  logic  is_cmp;

  always_comb begin
    result = '0;
    cmp    = 1'b0;
    is_cmp = 1'b0;
    case (req_i.op)
      ALU_ADD: result = req_i.a + req_i.b;
      ALU_SUB: result = req_i.a - req_i.b;
      ALU_AND: result = req_i.a & req_i.b;
      ALU_OR:  result = req_i.a | req_i.b;
      ALU_XOR: result = req_i.a ^ req_i.b;
      ALU_SLT: begin
        is_cmp = 1'b1;
        cmp    = $signed(req_i.a) < $signed(req_i.b);
      end
      ALU_SLTU: begin
        is_cmp = 1'b1;
        cmp    = req_i.a < req_i.b;
      end
      ALU_EQ: begin
        is_cmp = 1'b1;
        cmp    = req_i.a == req_i.b;
      end
      default: result = '0;
    endcase
    // Compare ops put the decision in bit 0
    if (is_cmp) begin
      result = {31'b0, cmp};
    end
    // Modelled upset on this lane's own bit
    result[LANE_ID] = result[LANE_ID] ^ inject_i;
  end

  assign res_o.result = result;
  assign res_o.cmp    = cmp;

endmodule

/* src/ft_ex_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types of the fault-tolerant execute stage, 4 lanes of 32 bits
// Compare ops return the compare bit zero-extended in the result word
////////////////////////////////////////////////////////////////////////////

package ft_ex_pkg;

  // Three voting lanes plus one spare
  localparam int NUM_LANES = 4;

  // Data word of one operand or result
  typedef logic [31:0] word_t;

  // Supported ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ
  } alu_op_e;

  // One request, same for every lane
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
  } alu_req_t;

  // Output of one lane
  // cmp is 0 for non-compare ops
  typedef struct packed {
    word_t result;
    logic  cmp;
  } lane_res_t;

  typedef logic [1:0]           lane_idx_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // Lanes taking part in the vote, first wins a three-way split
  typedef struct packed {
    lane_idx_t first;
    lane_idx_t second;
    lane_idx_t third;
  } lane_sel_t;

  // Voter flags
  typedef struct packed {
    logic detected;
    logic corrected;
  } vote_status_t;

  // Lost-vote counter, saturates at all ones
  typedef logic [8:0] fault_cnt_t;

  // Redundancy level of the stage
  typedef enum logic [1:0] {
    MODE_FULL,
    MODE_SPARED,
    MODE_DEGRADED
  } fault_mode_e;

endpackage
